// ==== tb.f ====
+incdir+hdl
+incdir+tb
hdl/rv_core_pkg.sv
hdl/rv_regfile.sv
hdl/rv_decode.sv
hdl/rv_op_queue.sv
hdl/rv_execute.sv
hdl/rv_core_top.sv
tb/tb_rv_core.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_rv_core
RTL_TOP    ?= rv_core_top
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a nonzero exit status.
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/rv_ref_model.svh ====
// **********************************************************
// Random RV32I word generator and in-order register model.
// Include inside the testbench module, after seed, last_rd, sent_count and model_regs.
// **********************************************************
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// Mostly legal OP and OP-IMM words, some LUI, about 5 percent bad words.
function automatic word_t gen_insn();
    logic [31:0] r;
    logic [31:0] r2;
    int          kind;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [6:0]  op;
    logic [11:0] imm;
    word_t       w;
    r    = $random(seed);
    r2   = $random(seed);
    kind = $unsigned($random(seed)) % 100;
    // Registers come from x0 to x7, so dependencies are frequent.
    rd   = {2'b00, r[2:0]};
    rs1  = r[3] ? last_rd : {2'b00, r[6:4]};
    rs2  = {2'b00, r[9:7]};
    f3   = r[12:10];
    f7   = r[13] ? `RV_FUNCT7_ALT : 7'b0000000;
    // Chain the next word onto this destination.
    last_rd = rd;
    if (kind < 3) begin
        // Opcode outside OP, OP-IMM and LUI.
        op = r2[6:0];
        if (op == `RV_OP_OP || op == `RV_OP_IMM || op == `RV_OP_LUI) begin
            op = 7'b1111111;
        end
        w = {r2[31:7], op};
    end else if (kind < 5) begin
        // SUB in immediate form, or a register form with funct7 bit 0 set.
        if (r[14]) begin
            w = {`RV_FUNCT7_ALT, r2[24:20], rs1, `RV_F3_ADD, rd, `RV_OP_IMM};
        end else begin
            w = {r2[31:26], 1'b1, rs2, rs1, f3, rd, `RV_OP_OP};
        end
    end else if (kind < 15) begin
        w = {r2[31:12], rd, `RV_OP_LUI};
    end else if (kind < 55) begin
        // Alternate funct7 only where SUB or SRA exists.
        if (f3 != `RV_F3_ADD && f3 != `RV_F3_SRL) begin
            f7 = 7'b0000000;
        end
        w = {f7, rs2, rs1, f3, rd, `RV_OP_OP};
    end else begin
        if (f3 == `RV_F3_SLL) begin
            imm = {7'b0000000, r2[4:0]};
        end else if (f3 == `RV_F3_SRL) begin
            imm = {f7, r2[4:0]};
        end else begin
            imm = r2[11:0];
        end
        w = {imm, rs1, f3, rd, `RV_OP_IMM};
    end
    // First words read every register once, ORI with a zero immediate.
    if (sent_count < `RV_REG_COUNT) begin
        w = {12'h000, reg_idx_t'(sent_count), `RV_F3_OR, rd, `RV_OP_IMM};
    end
    return w;
endfunction

// Expected retire for a word, applied to the model in accept order.
function automatic retire_t expect_retire(input word_t w);
    logic [6:0] op;
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      a;
    word_t      b;
    word_t      res;
    logic       bad;
    retire_t    t;
    op  = w[6:0];
    f3  = w[14:12];
    f7  = w[31:25];
    a   = model_regs[w[19:15]];
    b   = (op == `RV_OP_OP) ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
    bad = 1'b0;
    res = '0;
    if (op == `RV_OP_LUI) begin
        res = {w[31:12], 12'b0};
    end else if (op == `RV_OP_OP || op == `RV_OP_IMM) begin
        // Register form allows funct7 zero, or ALT for SUB and SRA.
        if (op == `RV_OP_OP) begin
            bad = !(f7 == 7'b0000000 ||
                    (f7 == `RV_FUNCT7_ALT && (f3 == `RV_F3_ADD || f3 == `RV_F3_SRL)));
        end else if (f3 == `RV_F3_SLL) begin
            bad = (f7 != 7'b0000000);
        end else if (f3 == `RV_F3_SRL) begin
            bad = !(f7 == 7'b0000000 || f7 == `RV_FUNCT7_ALT);
        end else if (f3 == `RV_F3_ADD) begin
            bad = (f7 == `RV_FUNCT7_ALT);
        end
        case (f3)
            `RV_F3_ADD: begin
                if (op == `RV_OP_OP && f7 == `RV_FUNCT7_ALT) begin
                    res = a - b;
                end else begin
                    res = a + b;
                end
            end
            `RV_F3_SLL:  res = a << b[4:0];
            `RV_F3_SLT:  res = {31'b0, $signed(a) < $signed(b)};
            `RV_F3_SLTU: res = {31'b0, a < b};
            `RV_F3_XOR:  res = a ^ b;
            `RV_F3_SRL: begin
                // Arithmetic shift keeps the sign.
                if (f7 == `RV_FUNCT7_ALT) begin
                    res = $signed(a) >>> b[4:0];
                end else begin
                    res = a >> b[4:0];
                end
            end
            `RV_F3_OR:   res = a | b;
            `RV_F3_AND:  res = a & b;
        endcase
    end else begin
        bad = 1'b1;
    end
    if (bad) begin
        t.rd      = '0;
        t.value   = '0;
        t.illegal = 1'b1;
    end else begin
        t.rd      = w[11:7];
        t.value   = res;
        t.illegal = 1'b0;
        // x0 is never written.
        if (w[11:7] != '0) begin
            model_regs[w[11:7]] = res;
        end
    end
    return t;
endfunction

`endif

// ==== tb/tb_rv_core.sv ====
// **********************************************************
// Random stream test of the core against an in-order model.
// Needs seeded $random and timing support; 10 ns clock.
// **********************************************************
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module tb_rv_core;
    import rv_core_pkg::*;

    localparam int NUM_INSNS  = 2000;
    localparam int MAX_CYCLES = NUM_INSNS * 8 + 200;

    logic    clk;
    logic    rst_latch;
    logic    insn_valid;
    logic    insn_ready;
    word_t   insn;
    logic    retire_valid;
    logic    retire_ready;
    retire_t retire;

    integer   seed;
    reg_idx_t last_rd;
    word_t    model_regs [`RV_REG_COUNT];
    retire_t  exp_q [$];
    int       sent_count;
    int       accepted_count;
    int       retired_count;
    int       cycle_count = 0;
    logic     stall_seen;
    retire_t  stall_val;

    `include "rv_ref_model.svh"

    rv_core_top i_rv_core_top (
        .clk, .rst_latch,
        .insn_valid, .insn_ready, .insn,
        .retire_valid, .retire_ready, .retire
    );

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string name, input word_t got, input word_t want);
        stop_with_failure($sformatf("FAILED at %0t: %s got %h, expected %h",
                                    $time, name, got, want));
    endtask

    // Compares rd, value and illegal of one retire.
    task automatic compare_retire(input string tag, input retire_t got, input retire_t want);
        assert (got.rd == want.rd)
            else report_mismatch({tag, ".rd"}, word_t'(got.rd), word_t'(want.rd));
        assert (got.value == want.value)
            else report_mismatch({tag, ".value"}, got.value, want.value);
        assert (got.illegal == want.illegal)
            else report_mismatch({tag, ".illegal"}, word_t'(got.illegal), word_t'(want.illegal));
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Run limit.
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            stop_with_failure("Run timed out before all instructions retired.");
        end
    end

    // Retire check, then accept into the model.
    // Retire comes first; a word never retires at its own accept edge.
    always @(posedge clk) begin
        if (!rst_latch) begin
            if (stall_seen) begin
                assert (retire_valid)
                    else stop_with_failure("retire_valid dropped while retire was stalled.");
                compare_retire("retire (held)", retire, stall_val);
            end
            if (retire_valid && retire_ready) begin
                assert (exp_q.size() > 0)
                    else stop_with_failure("Retire arrived with no accepted instruction left.");
                compare_retire("retire", retire, exp_q.pop_front());
                retired_count++;
            end
            if (insn_valid && insn_ready) begin
                exp_q.push_back(expect_retire(insn));
                accepted_count++;
            end
            stall_seen = retire_valid && !retire_ready;
            stall_val  = retire;
        end
    end

    initial begin
        seed           = 32'h7793;
        last_rd        = '0;
        sent_count     = 0;
        accepted_count = 0;
        retired_count  = 0;
        stall_seen     = 1'b0;
        stall_val      = '0;
        rst_latch      = 1'b1;
        insn_valid     = 1'b0;
        insn           = '0;
        retire_ready   = 1'b0;
        for (int i = 0; i < `RV_REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        // Eight reset edges, output stream idle throughout.
        repeat (8) begin
            @(posedge clk);
            @(negedge clk);
            assert (retire_valid == 1'b0)
                else report_mismatch("retire_valid", word_t'(retire_valid), '0);
        end
        rst_latch = 1'b0;
        assert (insn_ready == 1'b1)
            else report_mismatch("insn_ready", word_t'(insn_ready), 32'd1);
        while (retired_count < NUM_INSNS) begin
            // New word only after the last one was taken.
            if (sent_count == accepted_count) begin
                if (sent_count < NUM_INSNS && ($unsigned($random(seed)) % 100) >= 20) begin
                    insn       = gen_insn();
                    insn_valid = 1'b1;
                    sent_count++;
                end else begin
                    insn_valid = 1'b0;
                end
            end
            // Consumer stalls about 30 percent of cycles.
            retire_ready = ($unsigned($random(seed)) % 100) >= 30;
            @(negedge clk);
        end
        insn_valid   = 1'b0;
        retire_ready = 1'b1;
        // Idle edges to catch a duplicate retire.
        repeat (5) @(negedge clk);
        if (exp_q.size() == 0 && accepted_count == NUM_INSNS && retired_count == NUM_INSNS) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            stop_with_failure($sformatf("Count mismatch: %0d accepted, %0d retired, %0d pending.",
                                        accepted_count, retired_count, exp_q.size()));
        end
    end

endmodule

// ==== hdl/rv_core_top.sv ====
// **********************************************************
// RV32I register-to-register core, streamed in and out.
// Retire order matches accept order.
// **********************************************************
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_core_top (
    input  logic                 clk,
    input  logic                 rst_latch,
    input  logic                 insn_valid,
    output logic                 insn_ready,
    input  rv_core_pkg::word_t   insn,
    output logic                 retire_valid,
    input  logic                 retire_ready,
    output rv_core_pkg::retire_t retire
);
    import rv_core_pkg::*;

    // Decode to queue.
    logic        push_valid;
    logic        push_ready;
    decoded_op_t push_op;

    // Queue to execute.
    logic        pop_valid;
    logic        pop_ready;
    decoded_op_t pop_op;

    // Register file ports.
    logic                     wr_en;
    reg_idx_t                 wr_idx;
    word_t                    wr_data;
    reg_idx_t                 rd_idx_a;
    reg_idx_t                 rd_idx_b;
    word_t                    rd_data_a;
    word_t                    rd_data_b;
    logic [`RV_REG_COUNT-1:0] busy;
    logic                     set_busy;
    reg_idx_t                 set_idx;

    rv_decode i_rv_decode (
        .insn_valid, .insn_ready, .insn,
        .rd_idx_a, .rd_idx_b, .rd_data_a, .rd_data_b,
        .busy, .set_busy, .set_idx,
        .push_valid, .push_ready, .push_op
    );

    rv_op_queue #(.depth(`RV_QUEUE_DEPTH)) i_rv_op_queue (
        .clk, .rst_latch,
        .push_valid, .push_ready, .push_op,
        .pop_valid, .pop_ready, .pop_op
    );

    rv_execute i_rv_execute (
        .clk, .rst_latch,
        .pop_valid, .pop_ready, .pop_op,
        .wr_en, .wr_idx, .wr_data,
        .retire_valid, .retire_ready, .retire
    );

    rv_regfile i_rv_regfile (
        .clk, .rst_latch,
        .rd_idx_a, .rd_idx_b, .rd_data_a, .rd_data_b,
        .wr_en, .wr_idx, .wr_data,
        .set_busy, .set_idx, .busy
    );

endmodule

// ==== hdl/rv_execute.sv ====
// **********************************************************
// ALU and retire output register.
// Write-back happens at the edge that loads the retire slot.
// **********************************************************
`timescale 1ns/1ps

module rv_execute (
    input  logic                     clk,
    input  logic                     rst_latch,
    input  logic                     pop_valid,
    output logic                     pop_ready,
    input  rv_core_pkg::decoded_op_t pop_op,
    output logic                     wr_en,
    output rv_core_pkg::reg_idx_t    wr_idx,
    output rv_core_pkg::word_t       wr_data,
    output logic                     retire_valid,
    input  logic                     retire_ready,
    output rv_core_pkg::retire_t     retire
);
    import rv_core_pkg::*;

    word_t      lhs;
    word_t      rhs;
    logic [4:0] shamt;
    word_t      alu_result;
    logic       take;

    assign lhs   = pop_op.lhs;
    assign rhs   = pop_op.rhs;
    // Only the low 5 bits count for shifts.
    assign shamt = rhs[4:0];

    always_comb begin
        case (pop_op.alu_op)
            ALU_ADD:      alu_result = lhs + rhs;
            ALU_SUB:      alu_result = lhs - rhs;
            ALU_SLL:      alu_result = lhs << shamt;
            ALU_SLT:      alu_result = word_t'($signed(lhs) < $signed(rhs));
            ALU_SLTU:     alu_result = word_t'(lhs < rhs);
            ALU_XOR:      alu_result = lhs ^ rhs;
            ALU_SRL:      alu_result = lhs >> shamt;
            ALU_SRA:      alu_result = word_t'($signed(lhs) >>> shamt);
            ALU_OR:       alu_result = lhs | rhs;
            ALU_AND:      alu_result = lhs & rhs;
            ALU_PASS_RHS: alu_result = rhs;
            default:      alu_result = '0;
        endcase
    end

    // Accept when the retire slot is empty or draining this edge.
    assign pop_ready = !retire_valid || retire_ready;
    assign take      = pop_valid && pop_ready;

    // Register write-back.
    assign wr_en   = take && !pop_op.illegal && (pop_op.rd != '0);
    assign wr_idx  = pop_op.rd;
    assign wr_data = alu_result;

    always_ff @(posedge clk) begin
        if (rst_latch) begin
            retire_valid <= 1'b0;
        end else if (take) begin
            retire_valid <= 1'b1;
        end else if (retire_ready) begin
            retire_valid <= 1'b0;
        end
    end

    // Payload holds while the consumer stalls.
    always_ff @(posedge clk) begin
        if (take) begin
            retire.rd      <= pop_op.rd;
            retire.value   <= pop_op.illegal ? '0 : alu_result;
            retire.illegal <= pop_op.illegal;
        end
    end

endmodule

// ==== hdl/rv_op_queue.sv ====
// **********************************************************
// Circular FIFO of decoded operations, depth of 1 or more.
// When full, a push is accepted only alongside a pop.
// **********************************************************
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_op_queue #(
    parameter int depth = `RV_QUEUE_DEPTH
) (
    input  logic                     clk,
    input  logic                     rst_latch,
    input  logic                     push_valid,
    output logic                     push_ready,
    input  rv_core_pkg::decoded_op_t push_op,
    output logic                     pop_valid,
    input  logic                     pop_ready,
    output rv_core_pkg::decoded_op_t pop_op
);
    import rv_core_pkg::*;

    localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
    localparam int CNT_W = $clog2(depth + 1);

    decoded_op_t      mem [depth];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign pop_valid  = (count != '0);
    assign push_ready = (count != CNT_W'(depth)) || pop_ready;
    assign pop_op     = mem[rd_ptr];
    assign do_push    = push_valid && push_ready;
    assign do_pop     = pop_valid && pop_ready;

    // Entry storage.
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_op;
        end
    end

    // Pointers wrap at depth, not at a power of two.
    always_ff @(posedge clk) begin
        if (rst_latch) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== hdl/rv_decode.sv ====
// **********************************************************
// Combinational decode with a busy-bit interlock.
// Illegal words pass with rd zero and never wait on hazards.
// **********************************************************
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_decode (
    input  logic                     insn_valid,
    output logic                     insn_ready,
    input  rv_core_pkg::word_t       insn,
    output rv_core_pkg::reg_idx_t    rd_idx_a,
    output rv_core_pkg::reg_idx_t    rd_idx_b,
    input  rv_core_pkg::word_t       rd_data_a,
    input  rv_core_pkg::word_t       rd_data_b,
    input  logic [`RV_REG_COUNT-1:0] busy,
    output logic                     set_busy,
    output rv_core_pkg::reg_idx_t    set_idx,
    output logic                     push_valid,
    input  logic                     push_ready,
    output rv_core_pkg::decoded_op_t push_op
);
    import rv_core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    logic       is_op;
    logic       is_imm;
    logic       is_lui;
    logic       f7_base;
    logic       f7_alt;
    logic       illegal;
    alu_op_e    alu_op;
    reg_idx_t   rd_eff;
    logic       use_rs1;
    logic       use_rs2;
    logic       hazard;

    // Instruction fields.
    assign opcode  = insn[6:0];
    assign rd      = insn[11:7];
    assign funct3  = insn[14:12];
    assign rs1     = insn[19:15];
    assign rs2     = insn[24:20];
    assign funct7  = insn[31:25];
    assign is_op   = (opcode == `RV_OP_OP);
    assign is_imm  = (opcode == `RV_OP_IMM);
    assign is_lui  = (opcode == `RV_OP_LUI);
    assign f7_base = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == `RV_FUNCT7_ALT);

    // Operation select and legality.
    always_comb begin
        alu_op  = ALU_ADD;
        illegal = 1'b0;
        if (is_lui) begin
            alu_op = ALU_PASS_RHS;
        end else if (is_op || is_imm) begin
            case (funct3)
                `RV_F3_ADD: begin
                    alu_op  = (is_op && f7_alt) ? ALU_SUB : ALU_ADD;
                    // No SUB in immediate form.
                    illegal = is_imm ? f7_alt : !(f7_base || f7_alt);
                end
                `RV_F3_SLL: begin
                    alu_op  = ALU_SLL;
                    illegal = !f7_base;
                end
                `RV_F3_SRL: begin
                    alu_op  = f7_alt ? ALU_SRA : ALU_SRL;
                    illegal = !(f7_base || f7_alt);
                end
                `RV_F3_SLT:  alu_op = ALU_SLT;
                `RV_F3_SLTU: alu_op = ALU_SLTU;
                `RV_F3_XOR:  alu_op = ALU_XOR;
                `RV_F3_OR:   alu_op = ALU_OR;
                `RV_F3_AND:  alu_op = ALU_AND;
            endcase
            // Register forms only allow funct7 zero here.
            if (funct3 inside {`RV_F3_SLT, `RV_F3_SLTU, `RV_F3_XOR, `RV_F3_OR, `RV_F3_AND}) begin
                illegal = is_op && !f7_base;
            end
        end else begin
            illegal = 1'b1;
        end
    end

    // Source usage, and the destination that will really be written.
    assign use_rs1 = !illegal && (is_op || is_imm);
    assign use_rs2 = !illegal && is_op;
    assign rd_eff  = illegal ? '0 : rd;

    // Interlock on pending writes to sources or destination.
    // busy[0] is never set.
    assign hazard = (use_rs1 && busy[rs1]) || (use_rs2 && busy[rs2]) || busy[rd_eff];

    assign rd_idx_a = rs1;
    assign rd_idx_b = rs2;

    // Operands.
    assign push_op.alu_op  = alu_op;
    assign push_op.rd      = rd_eff;
    assign push_op.illegal = illegal;
    assign push_op.lhs     = is_lui ? '0 : rd_data_a;
    assign push_op.rhs     = is_op  ? rd_data_b :
                             is_lui ? {insn[31:12], 12'b0} :
                                      {{(`RV_XLEN-12){insn[31]}}, insn[31:20]};

    // Handshakes.
    assign push_valid = insn_valid && !hazard;
    assign insn_ready = push_ready && !hazard;
    assign set_busy   = insn_valid && insn_ready && (rd_eff != '0);
    assign set_idx    = rd_eff;

endmodule

// ==== hdl/rv_regfile.sv ====
// **********************************************************
// Register file, two read ports, one write port, no bypass.
// Busy bits track writes still in flight; set beats clear.
// **********************************************************
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_regfile (
    input  logic                     clk,
    input  logic                     rst_latch,
    input  rv_core_pkg::reg_idx_t    rd_idx_a,
    input  rv_core_pkg::reg_idx_t    rd_idx_b,
    output rv_core_pkg::word_t       rd_data_a,
    output rv_core_pkg::word_t       rd_data_b,
    input  logic                     wr_en,
    input  rv_core_pkg::reg_idx_t    wr_idx,
    input  rv_core_pkg::word_t       wr_data,
    input  logic                     set_busy,
    input  rv_core_pkg::reg_idx_t    set_idx,
    output logic [`RV_REG_COUNT-1:0] busy
);
    import rv_core_pkg::*;

    // x1 to x31 only.
    word_t regs [1:`RV_REG_COUNT-1];

    // x0 is hardwired to zero.
    assign rd_data_a = (rd_idx_a == '0) ? '0 : regs[rd_idx_a];
    assign rd_data_b = (rd_idx_b == '0) ? '0 : regs[rd_idx_b];

    // Registers start at zero after reset.
    always_ff @(posedge clk) begin
        if (rst_latch) begin
            for (int i = 1; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Pending write tracking.
    always_ff @(posedge clk) begin
        if (rst_latch) begin
            busy <= '0;
        end else begin
            if (wr_en) begin
                busy[wr_idx] <= 1'b0;
            end
            // Later assignment, so a new claim wins.
            if (set_busy) begin
                busy[set_idx] <= 1'b1;
            end
        end
    end

endmodule

// ==== hdl/rv_core_pkg.sv ====
// **********************************************************
// Types shared by the core blocks.
// Widths follow rv_core_defs.svh.
// **********************************************************
`include "rv_core_defs.svh"

package rv_core_pkg;

    // Architectural data word.
    typedef logic [`RV_XLEN-1:0] word_t;

    // Register number, x0 to x31.
    typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;

    // ALU operation.
    // PASS_RHS serves LUI.
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_RHS
    } alu_op_e;

    // Decoded operation, from decode through the queue to execute.
    // A zero rd means no register is written.
    typedef struct packed {
        alu_op_e  alu_op;
        reg_idx_t rd;
        word_t    lhs;
        word_t    rhs;
        logic     illegal;
    } decoded_op_t;

    // Retire stream payload.
    typedef struct packed {
        reg_idx_t rd;
        word_t    value;
        logic     illegal;
    } retire_t;

endpackage

// ==== hdl/rv_core_defs.svh ====
// **********************************************************
// Shared RV32I constants for the core and its testbench.
// Only the OP, OP-IMM and LUI encodings are recognised.
// **********************************************************
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// Data path and register file geometry.
`define RV_XLEN         32
`define RV_REG_COUNT    32
`define RV_REG_IDX_W    5

// Default depth of the decode to execute queue.
`define RV_QUEUE_DEPTH  2

// Major opcodes.
`define RV_OP_OP        7'b0110011
`define RV_OP_IMM       7'b0010011
`define RV_OP_LUI       7'b0110111

// Funct3 encodings shared by OP and OP-IMM.
`define RV_F3_ADD       3'b000
`define RV_F3_SLL       3'b001
`define RV_F3_SLT       3'b010
`define RV_F3_SLTU      3'b011
`define RV_F3_XOR       3'b100
`define RV_F3_SRL       3'b101
`define RV_F3_OR        3'b110
`define RV_F3_AND       3'b111

// Funct7 value selecting SUB and SRA.
`define RV_FUNCT7_ALT   7'b0100000

`endif
